// ==== verilog/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

    ////////////////////
    // opcode field
    localparam logic [5:0] opRType  = 6'h00;
    localparam logic [5:0] opRegImm = 6'h01;
    localparam logic [5:0] opJ      = 6'h02;
    localparam logic [5:0] opJal    = 6'h03;
    localparam logic [5:0] opBeq    = 6'h04;
    localparam logic [5:0] opBne    = 6'h05;
    localparam logic [5:0] opBlez   = 6'h06;
    localparam logic [5:0] opBgtz   = 6'h07;
    localparam logic [5:0] opAddi   = 6'h08;
    localparam logic [5:0] opLw     = 6'h23;
    localparam logic [5:0] opSw     = 6'h2b;

    // funct field, r-type only
    localparam logic [5:0] fnJr  = 6'h08;
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    // rt field under regimm
    localparam logic [4:0] rtBltz = 5'd0;
    localparam logic [4:0] rtBgez = 5'd1;

    // alu operation select
    localparam logic [3:0] aluAdd   = 4'd0;
    localparam logic [3:0] aluSub   = 4'd1;
    localparam logic [3:0] aluAnd   = 4'd2;
    localparam logic [3:0] aluOr    = 4'd3;
    localparam logic [3:0] aluSlt   = 4'd4;
    // execute looks at funct itself
    localparam logic [3:0] aluFunct = 4'd5;

    ////////////////////
    // instruction formats
    typedef struct packed {
        logic [5:0] op;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } rFormat_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } iFormat_t;

    typedef struct packed {
        logic [5:0]  op;
        logic [25:0] target;
    } jFormat_t;

    // same 32 bits, three views
    typedef union packed {
        rFormat_t r;
        iFormat_t i;
        jFormat_t j;
    } instrWord_u;

    // sll r0,r0,0 which decodes to an empty control word
    localparam instrWord_u nopWord = '0;

    ////////////////////
    // regDst 0 rt, 1 rd, 2 r31
    // memToReg 0 alu, 1 mem, 2 pc+4
    typedef struct packed {
        logic [1:0] regDst;
        logic       jump;
        logic       branch;
        logic       memRead;
        logic       memWrite;
        logic       aluSrc;
        logic       jumpReg;
        logic       regWrite;
        logic [1:0] memToReg;
        logic [3:0] aluOp;
    } ctrlWord_t;

    // everything execute needs from decode
    typedef struct packed {
        ctrlWord_t   ctrl;
        logic [31:0] pcPlus4;
        logic [31:0] readData1;
        logic [31:0] readData2;
        logic [31:0] signExtImm;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        logic [5:0]  funct;
    } idExBundle_t;

endpackage

`default_nettype wire

// ==== verilog/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  logic [5:0]         opcode,
    input  logic [5:0]         funct,
    input  logic [4:0]         rtField,
    // comparator flags
    input  logic               beq,
    input  logic               bne,
    input  logic               ltz,
    input  logic               gez,
    input  logic               gtz,
    input  logic               lez,
    output mipsPkg::ctrlWord_t ctrl,
    output logic               taken
);
    import mipsPkg::*;

    // branch condition picked by opcode
    logic cond;

    always_comb begin
        ctrl = '0;
        cond = 1'b0;
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd, fnSub, fnAnd, fnOr, fnSlt: begin
                        ctrl.regDst   = 2'd1;
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = aluFunct;
                    end
                    fnJr: begin
                        // target comes from rs
                        ctrl.jump    = 1'b1;
                        ctrl.jumpReg = 1'b1;
                    end
                    // nop and unknown funct stay empty
                    default: ;
                endcase
            end
            opRegImm: begin
                case (rtField)
                    rtBltz: begin
                        ctrl.branch = 1'b1;
                        cond        = ltz;
                    end
                    rtBgez: begin
                        ctrl.branch = 1'b1;
                        cond        = gez;
                    end
                    default: ;
                endcase
            end
            opJ: begin
                ctrl.jump = 1'b1;
            end
            opJal: begin
                // link into r31 with pc+4
                ctrl.jump     = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 2'd2;
                ctrl.memToReg = 2'd2;
            end
            opBeq: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                cond        = beq;
            end
            opBne: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = aluSub;
                cond        = bne;
            end
            opBlez: begin
                ctrl.branch = 1'b1;
                cond        = lez;
            end
            opBgtz: begin
                ctrl.branch = 1'b1;
                cond        = gtz;
            end
            opAddi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            opLw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 2'd1;
                ctrl.aluOp    = aluAdd;
            end
            opSw: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp    = aluAdd;
            end
            default: ;
        endcase
    end

    // jumps always taken, branches on their flag
    assign taken = (ctrl.branch && cond) || ctrl.jump;

endmodule

`default_nettype wire

// ==== verilog/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
    input  logic [4:0] ifIdRs,
    input  logic [4:0] ifIdRt,
    input  logic       usesRt,
    input  logic       isBranch,
    input  logic [4:0] idExRt,
    input  logic [4:0] idExDst,
    input  logic       idExMemRead,
    input  logic       idExRegWrite,
    input  logic [4:0] exMemRegDst,
    input  logic       exMemMemRead,
    output logic       stall,
    output logic       pcWrite,
    output logic       ifIdWrite
);

    logic loadUse;
    logic exDep;
    logic memDep;

    // load in ex, consumer in decode
    assign loadUse = idExMemRead && (idExRt != 5'd0) &&
                     ((idExRt == ifIdRs) || (usesRt && (idExRt == ifIdRt)));

    // compare happens in decode, so any pending ex result blocks it
    assign exDep = idExRegWrite && (idExDst != 5'd0) &&
                   ((idExDst == ifIdRs) || (usesRt && (idExDst == ifIdRt)));

    // load data not back until after mem
    assign memDep = exMemMemRead && (exMemRegDst != 5'd0) &&
                    ((exMemRegDst == ifIdRs) || (usesRt && (exMemRegDst == ifIdRt)));

    assign stall     = loadUse || (isBranch && (exDep || memDep));
    assign pcWrite   = !stall;
    assign ifIdWrite = !stall;

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`default_nettype none

module regFile (
    input  logic        Clk,
    input  logic        rst,
    input  logic [4:0]  readReg1,
    input  logic [4:0]  readReg2,
    output logic [31:0] readData1,
    output logic [31:0] readData2,
    input  logic        writeEn,
    input  logic [4:0]  writeReg,
    input  logic [31:0] writeData
);

    logic [31:0] regs [32];

    // write at the edge, r0 never written
    always_ff @(posedge Clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeReg != 5'd0)) begin
            regs[writeReg] <= writeData;
        end
    end

    // reads see the value from before this edge
    assign readData1 = regs[readReg1];
    assign readData2 = regs[readReg2];

    // r0 stays zero
    r0Fixed: assert property (
        @(posedge Clk) disable iff (rst)
        writeEn && (writeReg == 5'd0) |=> regs[0] == 32'd0
    );

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`default_nettype none

module decodeStage (
    input  logic                 Clk,
    input  logic                 rst,
    input  mipsPkg::instrWord_u  instr,
    input  logic [31:0]          pcPlus4,
    // feedback from id/ex
    input  logic [4:0]           idExRt,
    input  logic [4:0]           idExRd,
    input  logic [1:0]           idExRegDst,
    input  logic                 idExMemRead,
    input  logic                 idExRegWrite,
    // from mem stage
    input  logic [4:0]           exMemRegDst,
    input  logic                 exMemMemRead,
    // writeback port
    input  logic                 wbWrite,
    input  logic [4:0]           wbReg,
    input  logic [31:0]          wbData,
    output mipsPkg::idExBundle_t bundle,
    output logic                 stall,
    output logic                 pcWrite,
    output logic                 ifIdWrite,
    output logic                 flush,
    output logic                 redirect,
    output logic [31:0]          redirectTarget
);
    import mipsPkg::*;

    ctrlWord_t   ctrl;
    logic        taken;
    logic [31:0] readData1;
    logic [31:0] readData2;
    logic        isEq;
    logic        isLtz;
    logic        isZero;
    logic [31:0] signExtImm;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        usesRt;
    logic [4:0]  idExDst;

    regFile regs (
        .Clk       (Clk),
        .rst       (rst),
        .readReg1  (instr.r.rs),
        .readReg2  (instr.r.rt),
        .readData1 (readData1),
        .readData2 (readData2),
        .writeEn   (wbWrite),
        .writeReg  (wbReg),
        .writeData (wbData)
    );

    ////////////////////
    // branch compare
    assign isEq   = readData1 == readData2;
    assign isLtz  = readData1[31];
    assign isZero = readData1 == 32'd0;

    controlUnit ctl (
        .opcode  (instr.r.op),
        .funct   (instr.r.funct),
        .rtField (instr.i.rt),
        .beq     (isEq),
        .bne     (!isEq),
        .ltz     (isLtz),
        .gez     (!isLtz),
        .gtz     (!isLtz && !isZero),
        .lez     (isLtz || isZero),
        .ctrl    (ctrl),
        .taken   (taken)
    );

    ////////////////////
    // hazards
    // rt is a source for r-type, sw, beq and bne
    assign usesRt = (instr.r.op == opRType) || (instr.r.op == opSw) ||
                    (instr.r.op == opBeq) || (instr.r.op == opBne);

    // dest of the instruction now in ex
    always_comb begin
        case (idExRegDst)
            2'd1:    idExDst = idExRd;
            2'd2:    idExDst = 5'd31;
            default: idExDst = idExRt;
        endcase
    end

    hazardUnit hzd (
        .ifIdRs       (instr.r.rs),
        .ifIdRt       (instr.r.rt),
        .usesRt       (usesRt),
        .isBranch     (ctrl.branch || ctrl.jumpReg),
        .idExRt       (idExRt),
        .idExDst      (idExDst),
        .idExMemRead  (idExMemRead),
        .idExRegWrite (idExRegWrite),
        .exMemRegDst  (exMemRegDst),
        .exMemMemRead (exMemMemRead),
        .stall        (stall),
        .pcWrite      (pcWrite),
        .ifIdWrite    (ifIdWrite)
    );

    ////////////////////
    // targets
    assign signExtImm   = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign branchTarget = pcPlus4 + {signExtImm[29:0], 2'b00};
    // region of the delay slot pc
    assign jumpTarget   = {pcPlus4[31:28], instr.j.target, 2'b00};

    always_comb begin
        if (ctrl.jumpReg) begin
            redirectTarget = readData1;
        end else if (ctrl.jump) begin
            redirectTarget = jumpTarget;
        end else begin
            redirectTarget = branchTarget;
        end
    end

    // hold the redirect until operands are ready
    assign redirect = taken && !stall;
    assign flush    = redirect;

    assign bundle = '{
        ctrl:       ctrl,
        pcPlus4:    pcPlus4,
        readData1:  readData1,
        readData2:  readData2,
        signExtImm: signExtImm,
        rs:         instr.r.rs,
        rt:         instr.r.rt,
        rd:         instr.r.rd,
        shamt:      instr.r.shamt,
        funct:      instr.r.funct
    };

endmodule

`default_nettype wire

// ==== verilog/ifIdLatch.sv ====
`default_nettype none

module ifIdLatch (
    input  logic                Clk,
    input  logic                rst,
    input  logic                ifIdWrite,
    input  logic                flush,
    input  logic [31:0]         instrIn,
    input  logic [31:0]         pcPlus4In,
    output mipsPkg::instrWord_u instr,
    output logic [31:0]         pcPlus4
);
    import mipsPkg::*;

    // flush wins over hold
    always_ff @(posedge Clk) begin
        if (rst || flush) begin
            instr <= nopWord;
        end else if (ifIdWrite) begin
            instr <= instrIn;
        end
    end

    always_ff @(posedge Clk) begin
        if (ifIdWrite) begin
            pcPlus4 <= pcPlus4In;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/idExLatch.sv ====
`default_nettype none

module idExLatch (
    input  logic                 Clk,
    input  logic                 rst,
    input  logic                 stall,
    input  mipsPkg::idExBundle_t bundleIn,
    output mipsPkg::idExBundle_t bundleOut
);

    // data loads every cycle, only control is cleared
    always_ff @(posedge Clk) begin
        bundleOut <= bundleIn;
        if (rst || stall) begin
            bundleOut.ctrl <= '0;
        end
    end

    // a bubble must not touch regs or memory
    bubbleQuiet: assert property (
        @(posedge Clk) disable iff (rst)
        stall |=> !bundleOut.ctrl.regWrite && !bundleOut.ctrl.memWrite
    );

endmodule

`default_nettype wire

// ==== verilog/decodeTop.sv ====
`default_nettype none

module decodeTop (
    input  logic                 Clk,
    input  logic                 rst,
    // fetch side
    input  logic [31:0]          instrIn,
    input  logic [31:0]          pcPlus4In,
    // mem stage
    input  logic [4:0]           exMemRegDst,
    input  logic                 exMemMemRead,
    // writeback
    input  logic                 wbWrite,
    input  logic [4:0]           wbReg,
    input  logic [31:0]          wbData,
    output mipsPkg::idExBundle_t exBundle,
    output logic                 pcWrite,
    output logic                 redirect,
    output logic [31:0]          redirectTarget
);
    import mipsPkg::*;

    instrWord_u  instr;
    logic [31:0] pcPlus4;
    idExBundle_t bundle;
    logic        stall;
    logic        ifIdWrite;
    logic        flush;

    ifIdLatch ifId (
        .Clk       (Clk),
        .rst       (rst),
        .ifIdWrite (ifIdWrite),
        .flush     (flush),
        .instrIn   (instrIn),
        .pcPlus4In (pcPlus4In),
        .instr     (instr),
        .pcPlus4   (pcPlus4)
    );

    decodeStage dec (
        .Clk            (Clk),
        .rst            (rst),
        .instr          (instr),
        .pcPlus4        (pcPlus4),
        .idExRt         (exBundle.rt),
        .idExRd         (exBundle.rd),
        .idExRegDst     (exBundle.ctrl.regDst),
        .idExMemRead    (exBundle.ctrl.memRead),
        .idExRegWrite   (exBundle.ctrl.regWrite),
        .exMemRegDst    (exMemRegDst),
        .exMemMemRead   (exMemMemRead),
        .wbWrite        (wbWrite),
        .wbReg          (wbReg),
        .wbData         (wbData),
        .bundle         (bundle),
        .stall          (stall),
        .pcWrite        (pcWrite),
        .ifIdWrite      (ifIdWrite),
        .flush          (flush),
        .redirect       (redirect),
        .redirectTarget (redirectTarget)
    );

    idExLatch idEx (
        .Clk       (Clk),
        .rst       (rst),
        .stall     (stall),
        .bundleIn  (bundle),
        .bundleOut (exBundle)
    );

endmodule

`default_nettype wire

// ==== bench/decodeTb.sv ====
`default_nettype none

module decodeTb;
    timeunit 1ns;
    timeprecision 1ps;
    import mipsPkg::*;

    // one row of the decode table
    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc4;
        ctrlWord_t   ctrl;
        logic [31:0] imm;
        logic        redirect;
        logic [31:0] target;
        logic [4:0]  dst;
    } vecRec_t;

    ////////////////////
    // expected control words
    localparam ctrlWord_t ctlR = '{regDst: 2'd1, regWrite: 1'b1, aluOp: aluFunct, default: '0};
    localparam ctrlWord_t ctlJr = '{jump: 1'b1, jumpReg: 1'b1, default: '0};
    localparam ctrlWord_t ctlJ = '{jump: 1'b1, default: '0};
    localparam ctrlWord_t ctlJal = '{regDst: 2'd2, jump: 1'b1, regWrite: 1'b1,
                                     memToReg: 2'd2, default: '0};
    localparam ctrlWord_t ctlCmp = '{branch: 1'b1, aluOp: aluSub, default: '0};
    localparam ctrlWord_t ctlRegImm = '{branch: 1'b1, default: '0};
    localparam ctrlWord_t ctlAddi = '{aluSrc: 1'b1, regWrite: 1'b1, aluOp: aluAdd, default: '0};
    localparam ctrlWord_t ctlLw = '{memRead: 1'b1, aluSrc: 1'b1, regWrite: 1'b1,
                                    memToReg: 2'd1, aluOp: aluAdd, default: '0};
    localparam ctrlWord_t ctlSw = '{memWrite: 1'b1, aluSrc: 1'b1, aluOp: aluAdd, default: '0};

    logic        Clk;
    logic        rst;
    logic [31:0] instrIn;
    logic [31:0] pcPlus4In;
    logic [4:0]  exMemRegDst;
    logic        exMemMemRead;
    logic        wbWrite;
    logic [4:0]  wbReg;
    logic [31:0] wbData;
    idExBundle_t exBundle;
    logic        pcWrite;
    logic        redirect;
    logic [31:0] redirectTarget;

    // what the register file should hold
    logic [31:0] regModel [32];
    logic [31:0] lfsrState = 32'hcc59;
    vecRec_t     vectors[$];

    decodeTop uut (
        .Clk            (Clk),
        .rst            (rst),
        .instrIn        (instrIn),
        .pcPlus4In      (pcPlus4In),
        .exMemRegDst    (exMemRegDst),
        .exMemMemRead   (exMemMemRead),
        .wbWrite        (wbWrite),
        .wbReg          (wbReg),
        .wbData         (wbData),
        .exBundle       (exBundle),
        .pcWrite        (pcWrite),
        .redirect       (redirect),
        .redirectTarget (redirectTarget)
    );

    initial begin
        Clk = 1'b0;
        forever #50 Clk = ~Clk;
    end

    ////////////////////
    // instruction encoders
    function automatic logic [31:0] encodeR(input logic [4:0] rs, input logic [4:0] rt,
                                            input logic [4:0] rd, input logic [5:0] fn);
        return {opRType, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input logic [5:0] op, input logic [25:0] target);
        return {op, target};
    endfunction

    function automatic vecRec_t vecRow(input logic [31:0] instr, input logic [31:0] pc4,
                                       input ctrlWord_t ctrl, input logic [31:0] imm,
                                       input logic redir, input logic [31:0] target,
                                       input logic [4:0] dst);
        vecRec_t r;
        r.instr    = instr;
        r.pc4      = pc4;
        r.ctrl     = ctrl;
        r.imm      = imm;
        r.redirect = redir;
        r.target   = target;
        r.dst      = dst;
        return r;
    endfunction

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    task automatic randWord(output logic [31:0] w);
        w = '0;
        repeat (32) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    ////////////////////
    task automatic failRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    // count = extra negedges before pcWrite reached level
    task automatic waitPcWrite(input logic level, input int limit, output int count);
        count = 0;
        @(negedge Clk);
        while (pcWrite !== level) begin
            count++;
            if (count > limit) begin
                failRun("timeout while waiting for pcWrite to change");
            end
            @(negedge Clk);
        end
    endtask

    task automatic waitRedirect(input int limit);
        int n;
        n = 0;
        @(negedge Clk);
        while (redirect !== 1'b1) begin
            n++;
            if (n > limit) begin
                failRun("timeout while waiting for a redirect");
            end
            @(negedge Clk);
        end
    endtask

    task automatic writeReg(input logic [4:0] r, input logic [31:0] d);
        @(posedge Clk);
        wbWrite <= 1'b1;
        wbReg   <= r;
        wbData  <= d;
        // r0 is hard-wired
        if (r != 5'd0) begin
            regModel[r] = d;
        end
    endtask

    // isolated instruction, nops around it
    task automatic runVector(input vecRec_t v);
        logic [4:0] dst;
        @(posedge Clk);
        instrIn   <= v.instr;
        pcPlus4In <= v.pc4;
        @(posedge Clk);
        instrIn   <= 32'h0;
        pcPlus4In <= v.pc4 + 32'd4;
        // now sitting in decode
        @(negedge Clk);
        check("pcWrite", 32'(pcWrite), 32'd1);
        check("redirect", 32'(redirect), 32'(v.redirect));
        if (v.redirect) begin
            check("redirectTarget", redirectTarget, v.target);
        end
        @(posedge Clk);
        @(negedge Clk);
        check("exBundle.ctrl", 32'(exBundle.ctrl), 32'(v.ctrl));
        check("exBundle.signExtImm", exBundle.signExtImm, v.imm);
        check("exBundle.pcPlus4", exBundle.pcPlus4, v.pc4);
        check("exBundle.readData1", exBundle.readData1, regModel[v.instr[25:21]]);
        check("exBundle.readData2", exBundle.readData2, regModel[v.instr[20:16]]);
        // raw fields for execute
        check("exBundle.rs", 32'(exBundle.rs), 32'(v.instr[25:21]));
        check("exBundle.rt", 32'(exBundle.rt), 32'(v.instr[20:16]));
        check("exBundle.rd", 32'(exBundle.rd), 32'(v.instr[15:11]));
        check("exBundle.shamt", 32'(exBundle.shamt), 32'(v.instr[10:6]));
        check("exBundle.funct", 32'(exBundle.funct), 32'(v.instr[5:0]));
        if (v.ctrl.regWrite) begin
            case (exBundle.ctrl.regDst)
                2'd1:    dst = exBundle.rd;
                2'd2:    dst = 5'd31;
                default: dst = exBundle.rt;
            endcase
            check("dest register", 32'(dst), 32'(v.dst));
        end
    endtask

    // branch with a follower right behind it
    task automatic branchFollow(input logic [31:0] br, input logic [31:0] pc4,
                                input logic expTaken, input logic [31:0] nextInstr,
                                input ctrlWord_t expNext);
        @(posedge Clk);
        instrIn   <= br;
        pcPlus4In <= pc4;
        @(posedge Clk);
        instrIn   <= nextInstr;
        pcPlus4In <= pc4 + 32'd4;
        if (expTaken) begin
            waitRedirect(4);
        end else begin
            @(negedge Clk);
            check("redirect", 32'(redirect), 32'd0);
        end
        @(posedge Clk);
        instrIn   <= 32'h0;
        pcPlus4In <= pc4 + 32'd8;
        @(negedge Clk);
        check("exBundle.ctrl.branch", 32'(exBundle.ctrl.branch), 32'd1);
        @(posedge Clk);
        @(negedge Clk);
        check("follower ctrl", 32'(exBundle.ctrl), 32'(expNext));
        if (!expTaken) begin
            check("follower signExtImm", exBundle.signExtImm,
                  {{16{nextInstr[15]}}, nextInstr[15:0]});
        end
    endtask

    ////////////////////
    initial begin
        int          waited;
        logic [31:0] word;
        rst          = 1'b1;
        instrIn      = 32'h0;
        pcPlus4In    = 32'h0;
        exMemRegDst  = 5'd0;
        exMemMemRead = 1'b0;
        wbWrite      = 1'b0;
        wbReg        = 5'd0;
        wbData       = 32'h0;
        for (int i = 0; i < 32; i++) begin
            regModel[i] = 32'h0;
        end

        vectors.push_back(vecRow(encodeR(5'd1, 5'd2, 5'd3, fnAdd), 32'h0040_0004, ctlR,
                                 32'h0000_1820, 1'b0, 32'h0, 5'd3));
        vectors.push_back(vecRow(encodeR(5'd4, 5'd5, 5'd20, fnSub), 32'h0040_0008, ctlR,
                                 32'hffff_a022, 1'b0, 32'h0, 5'd20));
        vectors.push_back(vecRow(encodeR(5'd6, 5'd1, 5'd7, fnAnd), 32'h0040_000c, ctlR,
                                 32'h0000_3824, 1'b0, 32'h0, 5'd7));
        vectors.push_back(vecRow(encodeR(5'd2, 5'd3, 5'd11, fnOr), 32'h0040_0010, ctlR,
                                 32'h0000_5825, 1'b0, 32'h0, 5'd11));
        vectors.push_back(vecRow(encodeR(5'd7, 5'd0, 5'd31, fnSlt), 32'h0040_0014, ctlR,
                                 32'hffff_f82a, 1'b0, 32'h0, 5'd31));
        // r0 as a source after the write to it
        vectors.push_back(vecRow(encodeR(5'd0, 5'd1, 5'd6, fnAdd), 32'h0040_0018, ctlR,
                                 32'h0000_3020, 1'b0, 32'h0, 5'd6));
        vectors.push_back(vecRow(encodeR(5'd10, 5'd0, 5'd0, fnJr), 32'h0040_001c, ctlJr,
                                 32'h0000_0008, 1'b1, 32'h0040_1230, 5'd0));
        vectors.push_back(vecRow(encodeI(opAddi, 5'd1, 5'd4, 16'hfffd), 32'h0040_0020, ctlAddi,
                                 32'hffff_fffd, 1'b0, 32'h0, 5'd4));
        vectors.push_back(vecRow(encodeI(opLw, 5'd2, 5'd5, 16'h0040), 32'h0040_0024, ctlLw,
                                 32'h0000_0040, 1'b0, 32'h0, 5'd5));
        vectors.push_back(vecRow(encodeI(opSw, 5'd1, 5'd3, 16'hfff8), 32'h0040_0028, ctlSw,
                                 32'hffff_fff8, 1'b0, 32'h0, 5'd0));
        vectors.push_back(vecRow(encodeI(opBeq, 5'd8, 5'd8, 16'h0010), 32'h0040_0100, ctlCmp,
                                 32'h0000_0010, 1'b1, 32'h0040_0140, 5'd0));
        vectors.push_back(vecRow(encodeI(opBeq, 5'd8, 5'd9, 16'h0010), 32'h0040_0104, ctlCmp,
                                 32'h0000_0010, 1'b0, 32'h0, 5'd0));
        vectors.push_back(vecRow(encodeI(opBne, 5'd8, 5'd9, 16'hfff0), 32'h0040_0200, ctlCmp,
                                 32'hffff_fff0, 1'b1, 32'h0040_01c0, 5'd0));
        vectors.push_back(vecRow(encodeI(opBne, 5'd9, 5'd9, 16'hfff0), 32'h0040_0204, ctlCmp,
                                 32'hffff_fff0, 1'b0, 32'h0, 5'd0));
        vectors.push_back(vecRow(encodeI(opRegImm, 5'd8, rtBltz, 16'h0004), 32'h0040_0300,
                                 ctlRegImm, 32'h0000_0004, 1'b1, 32'h0040_0310, 5'd0));
        vectors.push_back(vecRow(encodeI(opRegImm, 5'd9, rtBltz, 16'h0004), 32'h0040_0304,
                                 ctlRegImm, 32'h0000_0004, 1'b0, 32'h0, 5'd0));
        vectors.push_back(vecRow(encodeI(opRegImm, 5'd9, rtBgez, 16'h8000), 32'h0044_0000,
                                 ctlRegImm, 32'hffff_8000, 1'b1, 32'h0042_0000, 5'd0));
        vectors.push_back(vecRow(encodeJ(opJ, 26'h010_0040), 32'h1000_0008, ctlJ,
                                 32'h0000_0040, 1'b1, 32'h1040_0100, 5'd0));
        vectors.push_back(vecRow(encodeJ(opJal, 26'h000_0100), 32'ha000_0010, ctlJal,
                                 32'h0000_0100, 1'b1, 32'ha000_0400, 5'd31));

        repeat (16) @(posedge Clk);
        rst <= 1'b0;
        @(negedge Clk);
        check("exBundle.ctrl after reset", 32'(exBundle.ctrl), 32'd0);
        check("pcWrite after reset", 32'(pcWrite), 32'd1);
        check("redirect after reset", 32'(redirect), 32'd0);

        // random data into r0..r7, fixed values for the branch tests
        for (int r = 0; r < 8; r++) begin
            randWord(word);
            writeReg(5'(r), word);
        end
        writeReg(5'd8, 32'h8000_0010);
        writeReg(5'd9, 32'h0000_0005);
        writeReg(5'd10, 32'h0040_1230);
        @(posedge Clk);
        wbWrite <= 1'b0;

        for (int k = 0; k < vectors.size(); k++) begin
            runVector(vectors[k]);
        end

        ////////////////////
        // taken beq squashes its follower, bne r3,r3 never does
        branchFollow(encodeI(opBeq, 5'd1, 5'd1, 16'h0020), 32'h0040_0400, 1'b1,
                     encodeI(opAddi, 5'd2, 5'd4, 16'h0123), '0);
        branchFollow(encodeI(opBne, 5'd3, 5'd3, 16'h0020), 32'h0040_0500, 1'b0,
                     encodeI(opAddi, 5'd2, 5'd4, 16'h0123), ctlAddi);

        // lw r5 then add r6,r5,r2
        @(posedge Clk);
        instrIn   <= encodeI(opLw, 5'd1, 5'd5, 16'h0010);
        pcPlus4In <= 32'h0040_0804;
        @(posedge Clk);
        instrIn   <= encodeR(5'd5, 5'd2, 5'd6, fnAdd);
        pcPlus4In <= 32'h0040_0808;
        @(posedge Clk);
        // held by the fetch side while pcWrite is low
        instrIn   <= encodeR(5'd1, 5'd2, 5'd7, fnOr);
        pcPlus4In <= 32'h0040_080c;
        waitPcWrite(1'b0, 4, waited);
        check("exBundle.ctrl.memRead", 32'(exBundle.ctrl.memRead), 32'd1);
        waitPcWrite(1'b1, 4, waited);
        check("load-use stall cycles", 32'(waited + 1), 32'd1);
        check("bubble ctrl", 32'(exBundle.ctrl), 32'd0);
        @(posedge Clk);
        instrIn <= 32'h0;
        @(negedge Clk);
        check("exBundle.ctrl after bubble", 32'(exBundle.ctrl), 32'(ctlR));
        check("exBundle.rd after bubble", 32'(exBundle.rd), 32'd6);
        check("exBundle.readData2 after bubble", exBundle.readData2, regModel[2]);

        repeat (3) @(posedge Clk);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
verilog/mipsPkg.sv
verilog/controlUnit.sv
verilog/hazardUnit.sv
verilog/regFile.sv
verilog/decodeStage.sv
verilog/ifIdLatch.sv
verilog/idExLatch.sv
verilog/decodeTop.sv
bench/decodeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module decodeTb \
    --Mdir build -o decodeSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./build/decodeSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" sim.log; then
    exit 0
fi
exit 1
